//--- files.f
verilog/gfx_pkg.sv
verilog/display_timings.sv
verilog/draw_line.sv
verilog/line_regs.sv
verilog/framebuffer.sv
verilog/line_display_top.sv
verif/tb_line_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the line display testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_line_display \
    -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_line_display)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verif/tb_line_display.sv
// tb_line_display: drives the line display over APB with random lines
// and checks the scanned pixel stream against a Bresenham model framebuffer

`default_nettype none
`timescale 1ns/100ps

module tb_line_display;
    import gfx_pkg::*;

    localparam int FRAME_CLKS  = 4480;                  // 80 x 56 raster
    localparam int WATCHDOG_NS = 40 * FRAME_CLKS * 4;

    logic        clk_pix;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    pix_out_t    pix;
    logic        busy;

    logic [CIDXW-1:0] model_fb [FB_HEIGHT][FB_WIDTH];
    int errors;
    int checks;
    int tests;
    int lines_done;  // expected STATUS count

    line_display_top line_display_top_i (
        .clk_pix, .rst,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .pix, .busy
    );

    always #2 clk_pix = ~clk_pix;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk_pix);
        #1;
        psel    = 1'b1;  // setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_pix);
        #1;
        penable = 1'b1;
        @(negedge clk_pix);
        checks++;
        if (pready !== 1'b1) report_value("pready", 32'(pready), 1);
        err = pslverr;
        @(posedge clk_pix);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk_pix);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk_pix);
        #1;
        penable = 1'b1;
        @(negedge clk_pix);
        checks++;
        if (pready !== 1'b1) report_value("pready", 32'(pready), 1);
        data = prdata;
        err  = pslverr;
        @(posedge clk_pix);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // poll STATUS until the busy bit drops
    task automatic wait_idle();
        logic [31:0] st;
        logic err;
        int polls;
        st    = 32'h1;
        polls = 0;
        while (st[0] && polls < 3000) begin
            apb_read(REG_STATUS, st, err);
            polls++;
        end
        checks++;
        if (st[0]) begin
            $display("busy flag still set after %0d status reads", polls);
            errors++;
        end else begin
            checks++;
            if (busy !== 1'b0) report_value("busy", 32'(busy), 0);
        end
    endtask

    task automatic check_count();
        logic [31:0] st;
        logic err;
        apb_read(REG_STATUS, st, err);
        checks++;
        if (st[15:8] !== 8'(lines_done)) report_value("status count", st[15:8], lines_done);
    endtask

    function automatic logic [23:0] expected_rgb(input logic [CIDXW-1:0] c);
        logic [11:0] p;
        p = PALETTE[c];
        return {p[11:8], p[11:8], p[7:4], p[7:4], p[3:0], p[3:0]};
    endfunction

    task automatic model_plot(input int x, input int y, input int c);
        if (x >= 0 && x < 32 && y >= 0 && y < 24) begin
            model_fb[y][x] = 4'(c);  // clipped like the memory
        end
    endtask

    // reference Bresenham, walks from the lower y end
    task automatic model_line(input int x0, input int y0, input int x1, input int y1,
                              input int c);
        int xa, ya, xb, yb, dx, dy, err, e2, x, y, step;
        bit last;
        if (y0 > y1) begin
            xa = x1;
            ya = y1;
            xb = x0;
            yb = y0;
        end else begin
            xa = x0;
            ya = y0;
            xb = x1;
            yb = y1;
        end
        dx   = (xa < xb) ? xb - xa : xa - xb;
        dy   = ya - yb;
        err  = dx + dy;
        step = (xa < xb) ? 1 : -1;
        x    = xa;
        y    = ya;
        last = 0;
        while (!last) begin
            model_plot(x, y, c);
            last = (x == xb) && (y == yb);
            e2 = 2 * err;  // both steps decided on the old error
            if (!last && e2 >= dy) begin
                err += dy;
                x   += step;
            end
            if (!last && e2 <= dx) begin
                err += dx;
                y   += 1;
            end
        end
    endtask

    task automatic load_line(input int x0, input int y0, input int x1, input int y1,
                             input int c);
        logic err;
        logic [31:0] vals [5];
        vals = '{32'(x0), 32'(y0), 32'(x1), 32'(y1), 32'(c)};
        for (int i = 0; i < 5; i++) begin
            apb_write(8'(i * 4), vals[i], err);
            checks++;
            if (err !== 1'b0) report_value("pslverr", 32'(err), 0);
        end
    endtask

    task automatic run_line(input int x0, input int y0, input int x1, input int y1,
                            input int c);
        logic err;
        load_line(x0, y0, x1, y1, c);
        model_line(x0, y0, x1, y1, c);
        apb_write(REG_CTRL, 32'h1, err);
        checks++;
        if (busy !== 1'b1) report_value("busy", 32'(busy), 1);
        wait_idle();
        lines_done++;
    endtask

    task automatic wait_frame();
        @(negedge clk_pix);
        while (pix.frame !== 1'b1) begin
            @(negedge clk_pix);
        end
    endtask

    // pixel position rebuilt by counting de from the frame strobe
    task automatic scan_frame();
        int n, px, py;
        logic [23:0] got, exp;
        n = 0;
        wait_frame();
        while (n < H_RES * V_RES) begin
            if (pix.de) begin
                px  = n % H_RES;
                py  = n / H_RES;
                exp = expected_rgb(model_fb[py / FB_SCALE][px / FB_SCALE]);
                got = {pix.red, pix.green, pix.blue};
                checks++;
                if (got !== exp) begin
                    errors++;
                    $display("error at %0t ns: pix rgb at (%0d,%0d) = %06h, expected %06h",
                             $time, px, py, got, exp);
                end
                n++;
            end
            @(negedge clk_pix);
        end
    endtask

    task automatic check_raster();
        int frames, cyc, de_run, de_lines, hs_run, vs_run;
        frames   = 0;
        cyc      = 0;
        de_run   = 0;
        de_lines = 0;
        hs_run   = 0;
        vs_run   = 0;
        wait_frame();
        while (frames < 3) begin
            if (pix.frame) begin
                if (frames > 0) begin
                    checks += 2;
                    if (cyc != FRAME_CLKS) report_value("frame period", cyc, FRAME_CLKS);
                    if (de_lines != 48) report_value("pix.de lines", de_lines, 48);
                end
                frames++;
                cyc      = 0;
                de_lines = 0;
            end
            if (frames < 3) begin
                if (pix.de) begin
                    de_run++;
                end else if (de_run > 0) begin  // end of an active line
                    checks++;
                    if (de_run != 64) report_value("pix.de width", de_run, 64);
                    de_lines++;
                    de_run = 0;
                end
                if (pix.hsync) begin
                    hs_run++;
                end else if (hs_run > 0) begin
                    checks++;
                    if (hs_run != 4) report_value("pix.hsync width", hs_run, 4);
                    hs_run = 0;
                end
                if (pix.vsync) begin
                    vs_run++;
                end else if (vs_run > 0) begin
                    checks++;
                    if (vs_run != 160) report_value("pix.vsync width", vs_run, 160);
                    vs_run = 0;
                end
                if (!pix.de) begin
                    checks++;
                    if ({pix.red, pix.green, pix.blue} !== 24'h0) begin
                        report_value("pix rgb in blanking", {pix.red, pix.green, pix.blue}, 0);
                    end
                end
                cyc++;
                @(negedge clk_pix);
            end
        end
    endtask

    task automatic finish_test(input string name, input int err0, input int chk0);
        tests++;
        $display("[%0t ns] %s: %0d checks, %0d errors", $time, name,
                 checks - chk0, errors - err0);
    endtask

    initial begin
        logic [31:0] v, rd, exp_rd;
        logic err;
        int e0, c0, x0, y0, x1, y1, c;
        clk_pix = 1'b0;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        lines_done = 0;
        for (int r = 0; r < FB_HEIGHT; r++) begin
            for (int q = 0; q < FB_WIDTH; q++) model_fb[r][q] = '0;
        end
        void'($urandom(10));
        repeat (16) @(posedge clk_pix);
        #1;
        rst = 1'b0;
        checks++;
        if (busy !== 1'b0) report_value("busy", 32'(busy), 0);

        // register readback
        e0 = errors;
        c0 = checks;
        for (int i = 0; i < 4; i++) begin
            v = $urandom();
            exp_rd = {{16{v[15]}}, v[15:0]};
            apb_write(8'(i * 4), v, err);
            checks++;
            if (err !== 1'b0) report_value("pslverr write", 32'(err), 0);
            apb_read(8'(i * 4), rd, err);
            checks += 2;
            if (rd !== exp_rd) report_value("prdata", rd, exp_rd);
            if (err !== 1'b0) report_value("pslverr", 32'(err), 0);
        end
        v = $urandom();
        apb_write(REG_COLOUR, v, err);
        checks++;
        if (err !== 1'b0) report_value("pslverr write colour", 32'(err), 0);
        apb_read(REG_COLOUR, rd, err);
        checks += 2;
        if (rd !== {28'b0, v[3:0]}) report_value("prdata colour", rd, {28'b0, v[3:0]});
        if (err !== 1'b0) report_value("pslverr", 32'(err), 0);
        apb_read(8'h20, rd, err);  // unmapped
        checks += 2;
        if (rd !== 32'h0) report_value("prdata unmapped", rd, 0);
        if (err !== 1'b1) report_value("pslverr unmapped", 32'(err), 1);
        finish_test("register readback", e0, c0);

        // one line inside the buffer
        e0 = errors;
        c0 = checks;
        x0 = $urandom_range(31, 0);
        y0 = $urandom_range(23, 0);
        x1 = $urandom_range(31, 0);
        y1 = $urandom_range(23, 0);
        run_line(x0, y0, x1, y1, $urandom_range(15, 1));
        check_count();
        scan_frame();
        finish_test("single line", e0, c0);

        // config writes while busy are refused
        e0 = errors;
        c0 = checks;
        x0 = $urandom_range(31, 0);
        y0 = $urandom_range(23, 0);
        x1 = $urandom_range(31, 0);
        y1 = $urandom_range(23, 0);
        c  = $urandom_range(15, 1);
        load_line(x0, y0, x1, y1, c);
        model_line(x0, y0, x1, y1, c);
        apb_write(REG_CTRL, 32'h1, err);
        checks++;
        if (busy !== 1'b1) report_value("busy", 32'(busy), 1);
        apb_write(REG_X0, 32'(x0 ^ 5), err);
        checks++;
        if (err !== 1'b1) report_value("pslverr busy x0", 32'(err), 1);
        apb_write(REG_COLOUR, 32'(c ^ 3), err);
        checks++;
        if (err !== 1'b1) report_value("pslverr busy colour", 32'(err), 1);
        apb_read(REG_X0, rd, err);
        checks++;
        if (rd !== 32'(x0)) report_value("prdata x0", rd, 32'(x0));
        wait_idle();
        lines_done++;
        check_count();
        scan_frame();
        finish_test("busy protection", e0, c0);

        // partly off-screen lines build up in the buffer
        e0 = errors;
        c0 = checks;
        for (int k = 0; k < 20; k++) begin
            x0 = int'($urandom_range(48, 0)) - 8;
            y0 = int'($urandom_range(48, 0)) - 8;
            x1 = int'($urandom_range(48, 0)) - 8;
            y1 = int'($urandom_range(48, 0)) - 8;
            run_line(x0, y0, x1, y1, $urandom_range(15, 0));
        end
        check_count();
        scan_frame();
        finish_test("clipping and many lines", e0, c0);

        e0 = errors;
        c0 = checks;
        check_raster();
        finish_test("raster timing", e0, c0);

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/line_display_top.sv
// line_display_top: timing, APB line registers, drawer and framebuffer
// pix stream lags the raster counters by two clocks

`default_nettype none
`timescale 1ns/100ps

module line_display_top
    import gfx_pkg::*;
(
    input  wire logic        clk_pix,
    input  wire logic        rst,
    input  wire logic [7:0]  paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output      logic [31:0] prdata,
    output      logic        pready,
    output      logic        pslverr,
    output      pix_out_t    pix,
    output      logic        busy
);

    logic signed [CORDW-1:0] sx, sy;
    logic hsync, vsync, de, frame;
    logic signed [CORDW-1:0] fbx, fby;  // drawer point
    line_req_t req;
    logic draw_start, drawing, draw_done;
    logic [7:0] fb_red, fb_green, fb_blue;
    logic [1:0] hsync_d, vsync_d, de_d, frame_d;

    display_timings display_timings_i (
        .clk_pix,
        .rst,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .frame,
        .line()
    );

    line_regs line_regs_i (
        .clk_pix, .rst,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .frame,
        .done(draw_done),
        .req,
        .start(draw_start),
        .busy
    );

    draw_line draw_line_i (
        .clk_pix, .rst,
        .start(draw_start),
        .req,
        .x(fbx), .y(fby),
        .drawing,
        .done(draw_done)
    );

    framebuffer framebuffer_i (
        .clk_pix, .rst,
        .we(drawing),
        .x(fbx), .y(fby),
        .cidx(req.cidx),
        .sx, .sy, .de,
        .red(fb_red), .green(fb_green), .blue(fb_blue)
    );

    // match memory read plus palette register
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hsync_d <= '0;
            vsync_d <= '0;
            de_d    <= '0;
            frame_d <= '0;
        end else begin
            hsync_d <= {hsync_d[0], hsync};
            vsync_d <= {vsync_d[0], vsync};
            de_d    <= {de_d[0], de};
            frame_d <= {frame_d[0], frame};
        end
    end

    always_comb begin
        pix.hsync = hsync_d[1];
        pix.vsync = vsync_d[1];
        pix.de    = de_d[1];
        pix.frame = frame_d[1];
        pix.red   = fb_red;
        pix.green = fb_green;
        pix.blue  = fb_blue;
    end

endmodule

`default_nettype wire

//--- verilog/framebuffer.sv
// framebuffer: 32x24 colour-index memory, written by the drawer
// and scanned 2x scaled through the palette to 8-bit channels

`default_nettype none
`timescale 1ns/100ps

module framebuffer
    import gfx_pkg::*;
(
    input  wire logic                    clk_pix,
    input  wire logic                    rst,
    input  wire logic                    we,
    input  wire logic signed [CORDW-1:0] x,
    input  wire logic signed [CORDW-1:0] y,
    input  wire logic [CIDXW-1:0]        cidx,
    input  wire logic signed [CORDW-1:0] sx,
    input  wire logic signed [CORDW-1:0] sy,
    input  wire logic                    de,
    output      logic [7:0]              red,
    output      logic [7:0]              green,
    output      logic [7:0]              blue
);

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;

    logic [CIDXW-1:0]    mem [FB_PIXELS];
    logic [FB_ADDRW-1:0] wr_addr, rd_addr;
    logic                wr_in;      // write lies inside the buffer
    logic [CIDXW-1:0]    cidx_rd;
    logic                de_p1;
    logic [3*CHANW-1:0]  rgb;

    // blank picture at power up
    initial begin
        for (int i = 0; i < FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    always_comb begin
        wr_in   = (x >= 0) && (x < FB_WIDTH) && (y >= 0) && (y < FB_HEIGHT);
        wr_addr = FB_ADDRW'(y * FB_WIDTH + x);
        // scaled scan position, parked at 0 in blanking
        rd_addr = de ? FB_ADDRW'((sy >>> FB_SHIFT) * FB_WIDTH + (sx >>> FB_SHIFT)) : '0;
    end

    always_ff @(posedge clk_pix) begin
        if (we && wr_in) begin
            mem[wr_addr] <= cidx;
        end
        cidx_rd <= mem[rd_addr];  // read every cycle
    end

    // palette stage, black outside active area
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            de_p1 <= 1'b0;
            rgb   <= '0;
        end else begin
            de_p1 <= de;
            rgb   <= de_p1 ? PALETTE[cidx_rd] : '0;
        end
    end

    // 4-bit channels doubled up to 8 bits
    assign red   = {2{rgb[3*CHANW-1:2*CHANW]}};
    assign green = {2{rgb[2*CHANW-1:CHANW]}};
    assign blue  = {2{rgb[CHANW-1:0]}};

endmodule

`default_nettype wire

//--- verilog/line_regs.sv
// line_regs: APB register file for the line endpoints and colour
// start waits for the next frame, busy until the drawer is done

`default_nettype none
`timescale 1ns/100ps

module line_regs
    import gfx_pkg::*;
(
    input  wire logic        clk_pix,
    input  wire logic        rst,
    input  wire logic [7:0]  paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output      logic [31:0] prdata,
    output      logic        pready,
    output      logic        pslverr,
    input  wire logic        frame,
    input  wire logic        done,
    output      line_req_t   req,
    output      logic        start,
    output      logic        busy
);

    ctrl_state_e state;
    logic [7:0]  line_count;  // completed lines
    logic        wr_en;
    logic        addr_ok;
    logic        cfg_addr;    // endpoint or colour register

    assign pready = 1'b1;  // no wait states
    assign busy   = (state != IDLE);

    // address decode and read mux
    always_comb begin
        wr_en    = psel && penable && pwrite;
        addr_ok  = 1'b1;
        cfg_addr = 1'b0;
        prdata   = '0;
        case (reg_addr_e'(paddr))
            REG_X0: begin
                cfg_addr = 1'b1;
                prdata   = 32'(req.x0);  // sign extended
            end
            REG_Y0: begin
                cfg_addr = 1'b1;
                prdata   = 32'(req.y0);
            end
            REG_X1: begin
                cfg_addr = 1'b1;
                prdata   = 32'(req.x1);
            end
            REG_Y1: begin
                cfg_addr = 1'b1;
                prdata   = 32'(req.y1);
            end
            REG_COLOUR: begin
                cfg_addr = 1'b1;
                prdata   = 32'(req.cidx);
            end
            REG_CTRL:   prdata = '0;
            REG_STATUS: prdata = {16'b0, line_count, 7'b0, busy};
            default:    addr_ok = 1'b0;  // unmapped
        endcase
        pslverr = psel && penable && (!addr_ok || (wr_en && busy && cfg_addr));
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state      <= IDLE;
            start      <= 1'b0;
            line_count <= '0;
            req        <= '0;
        end else begin
            start <= 1'b0;

            // request held stable while busy
            if (wr_en && !busy) begin
                case (reg_addr_e'(paddr))
                    REG_X0:     req.x0   <= pwdata[CORDW-1:0];
                    REG_Y0:     req.y0   <= pwdata[CORDW-1:0];
                    REG_X1:     req.x1   <= pwdata[CORDW-1:0];
                    REG_Y1:     req.y1   <= pwdata[CORDW-1:0];
                    REG_COLOUR: req.cidx <= pwdata[CIDXW-1:0];
                    default: ;
                endcase
            end

            case (state)
                IDLE: begin
                    if (wr_en && reg_addr_e'(paddr) == REG_CTRL && pwdata[0]) begin
                        state <= WAIT_FRAME;
                    end
                end
                WAIT_FRAME: begin
                    if (frame) begin
                        start <= 1'b1;
                        state <= DRAW;
                    end
                end
                DRAW: begin
                    if (done) begin
                        state      <= IDLE;
                        line_count <= line_count + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/draw_line.sv
// draw_line: Bresenham line drawer
// outputs one framebuffer point per clock from (x0,y0) to (x1,y1)

`default_nettype none
`timescale 1ns/100ps

module draw_line
    import gfx_pkg::*;
(
    input  wire logic               clk_pix,
    input  wire logic               rst,
    input  wire logic               start,
    input  wire line_req_t          req,
    output      logic signed [CORDW-1:0] x,
    output      logic signed [CORDW-1:0] y,
    output      logic               drawing,
    output      logic               done
);

    line_state_e state;

    // endpoints ordered so y always increases
    logic signed [CORDW-1:0] xa, ya, xb, yb;

    // wide enough for the doubled error term
    logic signed [CORDW+2:0] dx, dy, err;
    logic signed [CORDW+2:0] err2, err_next;
    logic signed [CORDW+2:0] dx_init, dy_init;
    logic right;  // x steps towards +x
    logic movx, movy;

    always_comb begin
        if (req.y0 > req.y1) begin
            xa = req.x1;
            ya = req.y1;
            xb = req.x0;
            yb = req.y0;
        end else begin
            xa = req.x0;
            ya = req.y0;
            xb = req.x1;
            yb = req.y1;
        end
    end

    // setup values for L_INIT
    always_comb begin
        dx_init = (xa < xb) ? xb - xa : xa - xb;  // abs
        dy_init = ya - yb;                        // never positive
    end

    // step decision for the current point
    always_comb begin
        err2     = err <<< 1;
        movx     = (err2 >= dy);
        movy     = (err2 <= dx);
        err_next = err;
        if (movx) begin
            err_next = err_next + dy;
        end
        if (movy) begin
            err_next = err_next + dx;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= L_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                L_IDLE: if (start) state <= L_INIT;
                L_INIT: state <= L_DRAW;
                L_DRAW: begin
                    if (x == xb && y == yb) begin
                        state <= L_IDLE;
                        done  <= 1'b1;  // cycle after last point
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_pix) begin
        if (state == L_INIT) begin
            x     <= xa;
            y     <= ya;
            dx    <= dx_init;
            dy    <= dy_init;
            err   <= dx_init + dy_init;
            right <= (xa < xb);
        end else if (state == L_DRAW && !(x == xb && y == yb)) begin
            if (movx) begin
                x <= right ? x + 1'b1 : x - 1'b1;
            end
            if (movy) begin
                y <= y + 1'b1;
            end
            err <= err_next;
        end
    end

    assign drawing = (state == L_DRAW);

endmodule

`default_nettype wire

//--- verilog/display_timings.sv
// display_timings: raster counters for the 64x48 mode
// with active-high syncs, data enable and frame/line strobes

`default_nettype none
`timescale 1ns/100ps

module display_timings
    import gfx_pkg::*;
(
    input  wire logic               clk_pix,
    input  wire logic               rst,
    output      logic signed [CORDW-1:0] sx,
    output      logic signed [CORDW-1:0] sy,
    output      logic               hsync,
    output      logic               vsync,
    output      logic               de,
    output      logic               frame,
    output      logic               line
);

    // blanking boundaries
    localparam int HS_STA = H_RES + H_FP;
    localparam int HS_END = HS_STA + H_SYNC;
    localparam int VS_STA = V_RES + V_FP;
    localparam int VS_END = VS_STA + V_SYNC;

    // horizontal counter wraps every 80 clocks
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (sx == H_TOTAL - 1) begin
                sx <= '0;
                if (sy == V_TOTAL - 1) begin
                    sy <= '0;  // new frame
                end else begin
                    sy <= sy + 1'b1;
                end
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // decode from current count
    always_comb begin
        hsync = (sx >= HS_STA) && (sx < HS_END);
        vsync = (sy >= VS_STA) && (sy < VS_END);
        de    = (sx < H_RES) && (sy < V_RES);
        frame = (sx == 0) && (sy == 0);
        line  = (sx == 0);  // start of every line
    end

endmodule

`default_nettype wire

//--- verilog/gfx_pkg.sv
// gfx_pkg: geometry, palette, state/register enums and structs
// shared by the line-drawing display subsystem

`default_nettype none

package gfx_pkg;

    // coordinates are signed
    localparam int CORDW = 16;

    // 64x48 active area in an 80x56 raster
    localparam int H_RES   = 64;
    localparam int V_RES   = 48;
    localparam int H_FP    = 4;
    localparam int H_SYNC  = 4;
    localparam int H_BP    = 8;
    localparam int V_FP    = 2;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 4;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 80
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 56

    // framebuffer is scaled up 2x on display
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 24;
    localparam int FB_SCALE  = 2;
    localparam int FB_SHIFT  = $clog2(FB_SCALE);
    localparam int FB_ADDRW  = 10;
    localparam int CIDXW     = 4;
    localparam int CHANW     = 4;

    // 12-bit RGB per colour index
    localparam logic [3*CHANW-1:0] PALETTE [16] = '{
        12'h000, 12'h1A2, 12'h34B, 12'h427,
        12'h825, 12'hA53, 12'h667, 12'hCCC,
        12'hF14, 12'hF90, 12'hFE2, 12'h1E3,
        12'h2AF, 12'h879, 12'hF8B, 12'hFDA
    };

    // APB word offsets
    typedef enum logic [7:0] {
        REG_X0     = 8'h00,
        REG_Y0     = 8'h04,
        REG_X1     = 8'h08,
        REG_Y1     = 8'h0C,
        REG_COLOUR = 8'h10,
        REG_CTRL   = 8'h14,  // bit 0 starts a line
        REG_STATUS = 8'h18   // bit 0 busy, 15:8 lines done
    } reg_addr_e;

    typedef enum logic [1:0] {IDLE, WAIT_FRAME, DRAW} ctrl_state_e;

    typedef enum logic [1:0] {L_IDLE, L_INIT, L_DRAW} line_state_e;

    typedef struct packed {
        logic signed [CORDW-1:0] x0;
        logic signed [CORDW-1:0] y0;
        logic signed [CORDW-1:0] x1;
        logic signed [CORDW-1:0] y1;
        logic [CIDXW-1:0]        cidx;
    } line_req_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic       frame;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pix_out_t;

endpackage

`default_nettype wire
